/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert --timing -f verilog.f --top-module decodeWbTb -o simv
	-./obj_dir/simv > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "Simulation finished: FAIL" $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* logic/decodeWbPkg.sv */
package decodeWbPkg;

    import rvIsaPkg::*;

    localparam int numRegs = 32;

    typedef logic [63:0] xlenWordT;
    typedef logic [31:0] instrWordT;
    typedef logic [4:0]  regIdxT;

    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10 // link value for jal/jalr
    } resultSrcT;

    typedef enum logic [1:0] {
        memNone  = 2'b00,
        memLoad  = 2'b01,
        memStore = 2'b10
    } memKindT;

    typedef struct packed {
        memKindT    kind;
        logic [2:0] size; // raw funct3
    } memAccessT;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        memAccessT memAccess;
        aluOpT     aluOp;
        logic      aluSrc; // 1 = immediate operand
        xlenWordT  imm;
        regIdxT    rs1;
        regIdxT    rs2;
        regIdxT    rd;
        logic      branch;
        logic      jump;
        logic      ecall;
    } decodedInstrT;

    typedef struct packed {
        logic     regWrite;
        regIdxT   rd;
        xlenWordT result;
    } writebackT;

endpackage

/* logic/decodeWbStage.sv */
module decodeWbStage
    import decodeWbPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  instrWordT    instr1,
    input  instrWordT    instr2,
    input  writebackT    wb1,
    input  writebackT    wb2,
    output decodedInstrT dec1,
    output decodedInstrT dec2,
    output xlenWordT     rs1Data1,
    output xlenWordT     rs2Data1,
    output xlenWordT     rs1Data2,
    output xlenWordT     rs2Data2
);

    instrDecoder lane1 (
        .instr(instr1),
        .dec  (dec1)
    );

    instrDecoder lane2 (
        .instr(instr2),
        .dec  (dec2)
    );

    // read addresses come from the decoded fields, zero when unused
    regFile rf (
        .clk     (clk),
        .rstN    (rstN),
        .wb1     (wb1),
        .wb2     (wb2),
        .rdAddr1a(dec1.rs1),
        .rdAddr1b(dec1.rs2),
        .rdAddr2a(dec2.rs1),
        .rdAddr2b(dec2.rs2),
        .rdData1a(rs1Data1),
        .rdData1b(rs2Data1),
        .rdData2a(rs1Data2),
        .rdData2b(rs2Data2)
    );

endmodule

/* logic/immGenerator.sv */
module immGenerator
    import rvIsaPkg::*, decodeWbPkg::*;
(
    input  instrWordT instr,
    input  immKindT   kind,
    output xlenWordT  imm
);

    logic signBit;

    assign signBit = instr[31];

    always_comb begin
        case (kind)
            immI: begin
                imm = {{52{signBit}}, instr[31:20]};
            end
            immS: begin
                imm = {{52{signBit}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                // bit 0 always zero, halfword aligned
                imm = {{52{signBit}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immU: begin
                imm = {{32{signBit}}, instr[31:12], 12'b0};
            end
            immJ: begin
                imm = {{44{signBit}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // immNone
            end
        endcase
    end

endmodule

/* logic/instrDecoder.sv */
module instrDecoder
    import rvIsaPkg::*, decodeWbPkg::*;
(
    input  instrWordT    instr,
    output decodedInstrT dec
);

    decodedInstrT ctrl;
    immKindT      immKind;
    xlenWordT     immVal;
    logic [2:0]   funct3;
    logic [6:0]   funct7;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    immGenerator immGen (
        .instr(instr),
        .kind (immKind),
        .imm  (immVal)
    );

    always_comb begin
        ctrl    = '0;
        immKind = immNone;
        ctrl.aluOp = aluNone;
        case (instr[6:0])
            opcLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resMem;
                ctrl.memAccess = '{kind: memLoad, size: funct3};
                ctrl.aluSrc    = 1'b1;
                ctrl.rs1       = instr[19:15];
                ctrl.rd        = instr[11:7];
                ctrl.aluOp     = aluAdd; // address calc
                immKind        = immI;
            end
            opcOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.rs1      = instr[19:15];
                ctrl.rd       = instr[11:7];
                immKind       = immI;
                case (funct3)
                    3'b000: ctrl.aluOp = aluAdd;
                    3'b001: ctrl.aluOp = aluSll;
                    3'b010: ctrl.aluOp = aluSlt;
                    3'b011: ctrl.aluOp = aluSltu;
                    3'b100: ctrl.aluOp = aluXor;
                    3'b101: begin
                        // shamt is 6 bits on RV64, bit 25 belongs to it
                        if (instr[31:26] == funct7Base[6:1]) begin
                            ctrl.aluOp = aluSrl;
                        end else if (instr[31:26] == funct7Alt[6:1]) begin
                            ctrl.aluOp = aluSra;
                        end
                    end
                    3'b110: ctrl.aluOp = aluOr;
                    default: ctrl.aluOp = aluAnd;
                endcase
            end
            opcAuipc, opcLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.rd       = instr[11:7];
                ctrl.aluOp    = (instr[6:0] == opcLui) ? aluLui : aluAuipc;
                immKind       = immU;
            end
            opcOpImm32: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.rs1      = instr[19:15];
                ctrl.rd       = instr[11:7];
                immKind       = immI;
                case (funct3)
                    3'b000: ctrl.aluOp = aluAddw;
                    3'b001: ctrl.aluOp = aluSllw;
                    3'b101: begin
                        if (funct7 == funct7Base) begin
                            ctrl.aluOp = aluSrlw;
                        end else if (funct7 == funct7Alt) begin
                            ctrl.aluOp = aluSraw;
                        end
                    end
                    default: ctrl.aluOp = aluNone;
                endcase
            end
            opcStore: begin
                ctrl.memAccess = '{kind: memStore, size: funct3};
                ctrl.aluSrc    = 1'b1;
                ctrl.rs1       = instr[19:15];
                ctrl.rs2       = instr[24:20];
                ctrl.rd        = instr[11:7]; // imm bits, regWrite stays low
                ctrl.aluOp     = aluAdd;
                immKind        = immS;
            end
            opcOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.rs1      = instr[19:15];
                ctrl.rs2      = instr[24:20];
                ctrl.rd       = instr[11:7];
                if (funct7 == funct7MulDiv) begin
                    case (funct3)
                        3'b000: ctrl.aluOp = aluMul;
                        3'b001: ctrl.aluOp = aluMulh;
                        3'b010: ctrl.aluOp = aluMulhsu;
                        3'b011: ctrl.aluOp = aluMulhu;
                        3'b100: ctrl.aluOp = aluDiv;
                        3'b101: ctrl.aluOp = aluDivu;
                        3'b110: ctrl.aluOp = aluRem;
                        default: ctrl.aluOp = aluRemu;
                    endcase
                end else if (funct7 == funct7Base) begin
                    case (funct3)
                        3'b000: ctrl.aluOp = aluAdd;
                        3'b001: ctrl.aluOp = aluSll;
                        3'b010: ctrl.aluOp = aluSlt;
                        3'b011: ctrl.aluOp = aluSltu;
                        3'b100: ctrl.aluOp = aluXor;
                        3'b101: ctrl.aluOp = aluSrl;
                        3'b110: ctrl.aluOp = aluOr;
                        default: ctrl.aluOp = aluAnd;
                    endcase
                end else if (funct7 == funct7Alt) begin
                    if (funct3 == 3'b000) begin
                        ctrl.aluOp = aluSub;
                    end else if (funct3 == 3'b101) begin
                        ctrl.aluOp = aluSra;
                    end
                end
            end
            opcOp32: begin
                ctrl.regWrite = 1'b1;
                ctrl.rs1      = instr[19:15];
                ctrl.rs2      = instr[24:20];
                ctrl.rd       = instr[11:7];
                case (funct3)
                    3'b000: begin
                        if (funct7 == funct7Base) begin
                            ctrl.aluOp = aluAddw;
                        end else if (funct7 == funct7MulDiv) begin
                            ctrl.aluOp = aluMulw;
                        end else if (funct7 == funct7Alt) begin
                            ctrl.aluOp = aluSubw;
                        end
                    end
                    3'b001: ctrl.aluOp = aluSllw;
                    3'b100: ctrl.aluOp = aluDivw; // funct7 not checked
                    3'b101: begin
                        if (funct7 == funct7Base) begin
                            ctrl.aluOp = aluSrlw;
                        end else if (funct7 == funct7MulDiv) begin
                            ctrl.aluOp = aluDivuw;
                        end else if (funct7 == funct7Alt) begin
                            ctrl.aluOp = aluSraw;
                        end
                    end
                    3'b110: ctrl.aluOp = aluRemw;
                    3'b111: ctrl.aluOp = aluRemuw;
                    default: ctrl.aluOp = aluNone;
                endcase
            end
            opcBranch: begin
                ctrl.branch = 1'b1;
                ctrl.rs1    = instr[19:15];
                ctrl.rs2    = instr[24:20];
                immKind     = immB;
                case (funct3)
                    3'b000: ctrl.aluOp = aluBeq;
                    3'b001: ctrl.aluOp = aluBne;
                    3'b100: ctrl.aluOp = aluBlt;
                    3'b101: ctrl.aluOp = aluBge;
                    3'b110: ctrl.aluOp = aluBltu;
                    3'b111: ctrl.aluOp = aluBgeu;
                    default: ctrl.aluOp = aluNone;
                endcase
            end
            opcJalr, opcJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resPcPlus4;
                ctrl.jump      = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.rd        = instr[11:7];
                if (instr[6:0] == opcJalr) begin
                    ctrl.rs1   = instr[19:15];
                    ctrl.aluOp = aluJalr;
                    immKind    = immI;
                end else begin
                    ctrl.aluOp = aluJal;
                    immKind    = immJ;
                end
            end
            opcSystem: begin
                if (funct3 == 3'b000 && instr[31:20] == 12'h000) begin
                    ctrl.ecall = 1'b1;
                    ctrl.aluOp = aluEcall;
                end
            end
            default: begin
                ctrl.aluOp = aluNone; // unknown opcode, bundle stays inactive
            end
        endcase
    end

    always_comb begin
        dec     = ctrl;
        dec.imm = immVal;
    end

endmodule

/* logic/regFile.sv */
module regFile
    import decodeWbPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  writebackT wb1,
    input  writebackT wb2,
    input  regIdxT    rdAddr1a,
    input  regIdxT    rdAddr1b,
    input  regIdxT    rdAddr2a,
    input  regIdxT    rdAddr2b,
    output xlenWordT  rdData1a,
    output xlenWordT  rdData1b,
    output xlenWordT  rdData2a,
    output xlenWordT  rdData2b
);

    xlenWordT regs [numRegs];
    logic     wr1En;
    logic     wr2En;

    assign wr2En = wb2.regWrite && (wb2.rd != '0);
    // lane 2 is younger, so it wins a same-rd collision
    assign wr1En = wb1.regWrite && (wb1.rd != '0) && !(wr2En && (wb1.rd == wb2.rd));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr1En) begin
                regs[wb1.rd] <= wb1.result;
            end
            if (wr2En) begin
                regs[wb2.rd] <= wb2.result;
            end
        end
    end

    function automatic xlenWordT readReg(input regIdxT addr);
        return (addr == '0) ? '0 : regs[addr]; // x0 hardwired
    endfunction

    // no bypass, a write shows up after the edge
    assign rdData1a = readReg(rdAddr1a);
    assign rdData1b = readReg(rdAddr1b);
    assign rdData2a = readReg(rdAddr2a);
    assign rdData2b = readReg(rdAddr2b);

endmodule

/* logic/rvIsaPkg.sv */
package rvIsaPkg;

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        opcLoad    = 7'b0000011,
        opcOpImm   = 7'b0010011,
        opcAuipc   = 7'b0010111,
        opcOpImm32 = 7'b0011011,
        opcStore   = 7'b0100011,
        opcOp      = 7'b0110011,
        opcLui     = 7'b0110111,
        opcOp32    = 7'b0111011,
        opcBranch  = 7'b1100011,
        opcJalr    = 7'b1100111,
        opcJal     = 7'b1101111,
        opcSystem  = 7'b1110011
    } opcodeT;

    typedef enum logic [2:0] {
        immNone = 3'd0,
        immI    = 3'd1,
        immS    = 3'd2,
        immB    = 3'd3,
        immU    = 3'd4,
        immJ    = 3'd5
    } immKindT;

    // numbering follows the execute stage ALU
    typedef enum logic [5:0] {
        aluNone   = 6'd0,
        aluSll    = 6'd1,
        aluSrl    = 6'd2,
        aluSra    = 6'd3,
        aluAdd    = 6'd4,
        aluSub    = 6'd5,
        aluDiv    = 6'd6,
        aluDivu   = 6'd7,
        aluRem    = 6'd8,
        aluRemu   = 6'd9,
        aluMul    = 6'd10,
        aluMulh   = 6'd11,
        aluMulhu  = 6'd12,
        aluMulhsu = 6'd13,
        aluXor    = 6'd14,
        aluOr     = 6'd15,
        aluAnd    = 6'd16,
        aluSlt    = 6'd17,
        aluSltu   = 6'd18,
        aluAuipc  = 6'd19,
        aluLui    = 6'd20,
        aluJalr   = 6'd21,
        aluJal    = 6'd22,
        aluBeq    = 6'd23,
        aluBne    = 6'd24,
        aluBlt    = 6'd25,
        aluBge    = 6'd26,
        aluBltu   = 6'd27,
        aluBgeu   = 6'd28,
        aluEcall  = 6'd29,
        aluSllw   = 6'd33, // 30..32 unused
        aluSrlw   = 6'd34,
        aluSraw   = 6'd35,
        aluAddw   = 6'd36,
        aluSubw   = 6'd37,
        aluDivw   = 6'd38,
        aluDivuw  = 6'd39,
        aluRemw   = 6'd40,
        aluRemuw  = 6'd41,
        aluMulw   = 6'd42
    } aluOpT;

    localparam logic [6:0] funct7Base   = 7'b0000000;
    localparam logic [6:0] funct7Alt    = 7'b0100000; // sub, sra
    localparam logic [6:0] funct7MulDiv = 7'b0000001; // M extension

endpackage

/* tests/decodeWbTb.sv */
module decodeWbTb
    import rvIsaPkg::*, decodeWbPkg::*;
;

    logic         clk;
    logic         rstN;
    instrWordT    instr1;
    instrWordT    instr2;
    writebackT    wb1;
    writebackT    wb2;
    decodedInstrT dec1;
    decodedInstrT dec2;
    xlenWordT     rs1Data1;
    xlenWordT     rs2Data1;
    xlenWordT     rs1Data2;
    xlenWordT     rs2Data2;

    string        nameTab [$];
    instrWordT    instrTab [$];
    decodedInstrT expTab [$];
    xlenWordT     refRegs [numRegs];
    int           errors;
    int           tests;

    decodeWbStage dut (
        .clk     (clk),
        .rstN    (rstN),
        .instr1  (instr1),
        .instr2  (instr2),
        .wb1     (wb1),
        .wb2     (wb2),
        .dec1    (dec1),
        .dec2    (dec2),
        .rs1Data1(rs1Data1),
        .rs2Data1(rs2Data1),
        .rs1Data2(rs1Data2),
        .rs2Data2(rs2Data2)
    );

    always #2 clk = ~clk;

    function automatic decodedInstrT ctl(input logic rw, input resultSrcT res,
                                         input memKindT mk, input logic [2:0] msz,
                                         input aluOpT op, input logic src,
                                         input xlenWordT imm, input regIdxT rs1,
                                         input regIdxT rs2, input regIdxT rd,
                                         input logic br, input logic jmp,
                                         input logic ec);
        decodedInstrT d;
        d.regWrite       = rw;
        d.resultSrc      = res;
        d.memAccess.kind = mk;
        d.memAccess.size = msz;
        d.aluOp          = op;
        d.aluSrc         = src;
        d.imm            = imm;
        d.rs1            = rs1;
        d.rs2            = rs2;
        d.rd             = rd;
        d.branch         = br;
        d.jump           = jmp;
        d.ecall          = ec;
        return d;
    endfunction

    // OP add with rd = x0, used only to steer the read ports
    function automatic instrWordT readInstr(input regIdxT a, input regIdxT b);
        return {7'b0000000, b, a, 3'b000, 5'd0, 7'b0110011};
    endfunction

    task automatic addEntry(input string name, input instrWordT ins, input decodedInstrT exp);
        nameTab.push_back(name);
        instrTab.push_back(ins);
        expTab.push_back(exp);
    endtask

    task automatic buildTable();
        addEntry("ld", 32'hFF813283, ctl(1, resMem, memLoad, 3'd3, aluAdd, 1,
                 64'hFFFF_FFFF_FFFF_FFF8, 5'd2, 5'd0, 5'd5, 0, 0, 0));
        addEntry("addi", 32'h7FF00093, ctl(1, resAlu, memNone, 3'd0, aluAdd, 1,
                 64'h7FF, 5'd0, 5'd0, 5'd1, 0, 0, 0));
        addEntry("srai", 32'h43F25193, ctl(1, resAlu, memNone, 3'd0, aluSra, 1,
                 64'h43F, 5'd4, 5'd0, 5'd3, 0, 0, 0));
        addEntry("addiw", 32'hFFF1011B, ctl(1, resAlu, memNone, 3'd0, aluAddw, 1,
                 64'hFFFF_FFFF_FFFF_FFFF, 5'd2, 5'd0, 5'd2, 0, 0, 0));
        addEntry("mulhu", 32'h02C5B533, ctl(1, resAlu, memNone, 3'd0, aluMulhu, 0,
                 64'h0, 5'd11, 5'd12, 5'd10, 0, 0, 0));
        addEntry("subw", 32'h409403BB, ctl(1, resAlu, memNone, 3'd0, aluSubw, 0,
                 64'h0, 5'd8, 5'd9, 5'd7, 0, 0, 0));
        addEntry("sd", 32'hFE613823, ctl(0, resAlu, memStore, 3'd3, aluAdd, 1,
                 64'hFFFF_FFFF_FFFF_FFF0, 5'd2, 5'd6, 5'd16, 0, 0, 0));
        addEntry("sw", 32'h1251A223, ctl(0, resAlu, memStore, 3'd2, aluAdd, 1,
                 64'h124, 5'd3, 5'd5, 5'd4, 0, 0, 0));
        addEntry("bne", 32'hFE209EE3, ctl(0, resAlu, memNone, 3'd0, aluBne, 0,
                 64'hFFFF_FFFF_FFFF_FFFC, 5'd1, 5'd2, 5'd0, 1, 0, 0));
        addEntry("beq", 32'h00418463, ctl(0, resAlu, memNone, 3'd0, aluBeq, 0,
                 64'h8, 5'd3, 5'd4, 5'd0, 1, 0, 0));
        addEntry("jal+", 32'h001000EF, ctl(1, resPcPlus4, memNone, 3'd0, aluJal, 1,
                 64'h800, 5'd0, 5'd0, 5'd1, 0, 1, 0));
        addEntry("jal-", 32'hFFFFF06F, ctl(1, resPcPlus4, memNone, 3'd0, aluJal, 1,
                 64'hFFFF_FFFF_FFFF_FFFE, 5'd0, 5'd0, 5'd0, 0, 1, 0));
        addEntry("jalr", 32'h00C302E7, ctl(1, resPcPlus4, memNone, 3'd0, aluJalr, 1,
                 64'hC, 5'd6, 5'd0, 5'd5, 0, 1, 0));
        addEntry("lui", 32'h800004B7, ctl(1, resAlu, memNone, 3'd0, aluLui, 1,
                 64'hFFFF_FFFF_8000_0000, 5'd0, 5'd0, 5'd9, 0, 0, 0));
        addEntry("auipc", 32'h12345217, ctl(1, resAlu, memNone, 3'd0, aluAuipc, 1,
                 64'h1234_5000, 5'd0, 5'd0, 5'd4, 0, 0, 0));
        addEntry("ecall", 32'h00000073, ctl(0, resAlu, memNone, 3'd0, aluEcall, 0,
                 64'h0, 5'd0, 5'd0, 5'd0, 0, 0, 1));
        addEntry("unknown", 32'hFFFFFFFF, ctl(0, resAlu, memNone, 3'd0, aluNone, 0,
                 64'h0, 5'd0, 5'd0, 5'd0, 0, 0, 0));
    endtask

    task automatic compareField(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkDecode(input string lane, input decodedInstrT got,
                               input decodedInstrT exp);
        compareField({lane, ".regWrite"}, 64'(got.regWrite), 64'(exp.regWrite));
        compareField({lane, ".resultSrc"}, 64'(got.resultSrc), 64'(exp.resultSrc));
        compareField({lane, ".memAccess"}, 64'(got.memAccess), 64'(exp.memAccess));
        compareField({lane, ".aluOp"}, 64'(got.aluOp), 64'(exp.aluOp));
        compareField({lane, ".aluSrc"}, 64'(got.aluSrc), 64'(exp.aluSrc));
        compareField({lane, ".imm"}, got.imm, exp.imm);
        compareField({lane, ".rs1"}, 64'(got.rs1), 64'(exp.rs1));
        compareField({lane, ".rs2"}, 64'(got.rs2), 64'(exp.rs2));
        compareField({lane, ".rd"}, 64'(got.rd), 64'(exp.rd));
        compareField({lane, ".branch"}, 64'(got.branch), 64'(exp.branch));
        compareField({lane, ".jump"}, 64'(got.jump), 64'(exp.jump));
        compareField({lane, ".ecall"}, 64'(got.ecall), 64'(exp.ecall));
    endtask

    // all four ports against the reference, lane 1 reads a/b, lane 2 reads c/d
    task automatic checkReads(input regIdxT a, input regIdxT b, input regIdxT c,
                              input regIdxT d);
        compareField("rs1Data1", rs1Data1, refRegs[a]);
        compareField("rs2Data1", rs2Data1, refRegs[b]);
        compareField("rs1Data2", rs1Data2, refRegs[c]);
        compareField("rs2Data2", rs2Data2, refRegs[d]);
    endtask

    task automatic reportTest(input string name, input int errBefore);
        tests++;
        if (errors == errBefore) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errBefore);
        end
    endtask

    task automatic sweepRegs(input string name);
        int errBefore;
        errBefore = errors;
        for (int r = 0; r < numRegs; r += 2) begin
            @(negedge clk);
            instr1 = readInstr(5'(r), 5'(r + 1));
            instr2 = readInstr(5'(r + 1), 5'(r));
            #1;
            checkReads(5'(r), 5'(r + 1), 5'(r + 1), 5'(r));
        end
        reportTest(name, errBefore);
    endtask

    task automatic applyWrite(input string name, input writebackT w1, input writebackT w2);
        int errBefore;
        errBefore = errors;
        @(negedge clk);
        wb1 = w1;
        wb2 = w2;
        instr1 = readInstr(w1.rd, w2.rd);
        instr2 = readInstr(w2.rd, w1.rd);
        #1;
        checkReads(w1.rd, w2.rd, w2.rd, w1.rd); // old values before the edge
        @(posedge clk);
        if (w1.regWrite && w1.rd != 5'd0) begin
            refRegs[w1.rd] = w1.result;
        end
        if (w2.regWrite && w2.rd != 5'd0) begin
            refRegs[w2.rd] = w2.result; // applied last so lane 2 wins
        end
        @(negedge clk);
        checkReads(w1.rd, w2.rd, w2.rd, w1.rd);
        wb1 = '0;
        wb2 = '0;
        reportTest(name, errBefore);
    endtask

    function automatic writebackT mkWb(input logic rw, input regIdxT rd);
        writebackT w;
        w.regWrite = rw;
        w.rd       = rd;
        w.result   = {$urandom(), $urandom()};
        return w;
    endfunction

    initial begin
        int errBefore;
        void'($urandom(5874));
        clk    = 1'b0;
        rstN   = 1'b0;
        instr1 = '0;
        instr2 = '0;
        wb1    = '0;
        wb2    = '0;
        errors = 0;
        tests  = 0;
        for (int r = 0; r < numRegs; r++) begin
            refRegs[r] = '0;
        end
        buildTable();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int i = 0; i < instrTab.size(); i++) begin
            errBefore = errors;
            @(negedge clk);
            instr1 = instrTab[i];
            instr2 = '0;
            #1;
            checkDecode("dec1", dec1, expTab[i]);
            @(negedge clk);
            instr1 = '0;
            instr2 = instrTab[i];
            #1;
            checkDecode("dec2", dec2, expTab[i]);
            reportTest({"decode ", nameTab[i]}, errBefore);
        end

        sweepRegs("all zero after reset");
        applyWrite("wb1 to x5", mkWb(1, 5'd5), mkWb(0, 5'd0));
        applyWrite("wb2 to x7", mkWb(0, 5'd0), mkWb(1, 5'd7));
        applyWrite("write to x0", mkWb(1, 5'd0), mkWb(1, 5'd0));
        applyWrite("same rd x9", mkWb(1, 5'd9), mkWb(1, 5'd9));
        applyWrite("x3 and x4", mkWb(1, 5'd3), mkWb(1, 5'd4));
        applyWrite("disabled write x6", mkWb(0, 5'd6), mkWb(0, 5'd5));
        for (int i = 0; i < 12; i++) begin
            applyWrite($sformatf("random write %0d", i),
                       mkWb(1'($urandom()), 5'($urandom_range(0, 31))),
                       mkWb(1'($urandom()), 5'($urandom_range(0, 31))));
        end
        applyWrite("x1 and x31", mkWb(1, 5'd1), mkWb(1, 5'd31));
        sweepRegs("register contents");

        // unknown opcodes leave rs1/rs2 at zero, so x0 is read
        errBefore = errors;
        @(negedge clk);
        instr1 = 32'h0010807F; // fields name x1
        instr2 = 32'hFFFFFFFF; // fields name x31
        #1;
        checkReads(5'd0, 5'd0, 5'd0, 5'd0);
        reportTest("unknown opcode reads", errBefore);

        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* tests/regFile_assertions.sv */
module regFileAssertions
    import decodeWbPkg::*;
(
    input logic      clk,
    input logic      rstN,
    input writebackT wb1,
    input writebackT wb2,
    input regIdxT    rdAddr1a,
    input regIdxT    rdAddr1b,
    input regIdxT    rdAddr2a,
    input regIdxT    rdAddr2b,
    input xlenWordT  rdData1a,
    input xlenWordT  rdData1b,
    input xlenWordT  rdData2a,
    input xlenWordT  rdData2b,
    input xlenWordT  regs [numRegs]
);

    logic written; // set by the first real write after reset
    logic anyWrite;

    assign anyWrite = (wb1.regWrite && wb1.rd != 5'd0) || (wb2.regWrite && wb2.rd != 5'd0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            written <= 1'b0;
        end else if (anyWrite) begin
            written <= 1'b1;
        end
    end

    x0Reads: assert property (@(posedge clk) disable iff (!rstN)
        (rdAddr1a != 5'd0 || rdData1a == '0) && (rdAddr1b != 5'd0 || rdData1b == '0) &&
        (rdAddr2a != 5'd0 || rdData2a == '0) && (rdAddr2b != 5'd0 || rdData2b == '0))
        else $error("x0 read returned a nonzero value");

    zeroAfterReset: assert property (@(posedge clk) disable iff (!rstN)
        !written |-> (rdData1a == '0 && rdData1b == '0 && rdData2a == '0 && rdData2b == '0))
        else $error("read port nonzero before any write after reset");

    lane2Wins: assert property (@(posedge clk) disable iff (!rstN)
        (wb1.regWrite && wb2.regWrite && wb1.rd == wb2.rd && wb2.rd != 5'd0)
        |=> regs[$past(wb2.rd)] == $past(wb2.result))
        else $error("same-rd dual write did not keep the lane 2 result");

endmodule

bind regFile regFileAssertions rfChecks (.*);

/* verilog.f */
logic/rvIsaPkg.sv
logic/decodeWbPkg.sv
logic/immGenerator.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/decodeWbStage.sv
tests/regFile_assertions.sv
tests/decodeWbTb.sv
